// File: verilog/axi_params.svh
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Master side ID width
`define AXI_ID_BITS 4

// Slave side ID carries the master index above the master ID
`define AXI_IDS_BITS 8

`define AXI_ADDR_BITS 32
`define AXI_LEN_BITS 4
`define AXI_SIZE_BITS 3

// Address map
// S0 at 0x0000_0000 to 0x0000_FFFF
`define AXI_S0_BASE 32'h0000_0000
`define AXI_S0_MASK 32'hFFFF_0000

// S1 at 0x0001_0000 to 0x0001_FFFF
`define AXI_S1_BASE 32'h0001_0000
`define AXI_S1_MASK 32'hFFFF_0000

`endif

// File: verilog/axi_pkg.sv
`include "axi_params.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    LOCK_FREE = 2'b00,
    LOCK_M0   = 2'b01,
    LOCK_M1   = 2'b10
  } addr_arb_lock_t;

  typedef logic [`AXI_IDS_BITS-`AXI_ID_BITS-1:0] mst_idx_t;

  localparam mst_idx_t MST_IDX_0 = mst_idx_t'(0);
  localparam mst_idx_t MST_IDX_1 = mst_idx_t'(1);

  typedef struct packed {
    mst_idx_t                 mst;
    logic [`AXI_ID_BITS-1:0]  id;
  } ext_id_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    burst_t                    burst;
  } addr_chan_t;

  typedef struct packed {
    ext_id_t                   ids;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    burst_t                    burst;
  } slv_addr_chan_t;

  typedef struct packed {
    logic    valid;
    ext_id_t ids;
  } decerr_t;

  // Master request seen from the slave side
  function automatic slv_addr_chan_t extend_req(input addr_chan_t req, input mst_idx_t mst);
    slv_addr_chan_t slv;
    slv.ids.mst = mst;
    slv.ids.id  = req.id;
    slv.addr    = req.addr;
    slv.len     = req.len;
    slv.size    = req.size;
    slv.burst   = req.burst;
    return slv;
  endfunction

endpackage

// File: verilog/addr_map_pkg.sv
`include "axi_params.svh"

package addr_map_pkg;

  typedef enum logic [1:0] {
    SLAVE_0   = 2'b00,
    SLAVE_1   = 2'b01,
    SLAVE_DEF = 2'b10
  } slave_sel_t;

  // Anything outside both windows goes to the default slave
  function automatic slave_sel_t addr_decode(input logic [`AXI_ADDR_BITS-1:0] addr);
    slave_sel_t sel;
    logic       hit_s0;
    logic       hit_s1;
    hit_s0 = ((addr & `AXI_S0_MASK) == `AXI_S0_BASE);
    hit_s1 = ((addr & `AXI_S1_MASK) == `AXI_S1_BASE);
    if (hit_s0) begin
      sel = SLAVE_0;
    end else if (hit_s1) begin
      sel = SLAVE_1;
    end else begin
      sel = SLAVE_DEF;
    end
    return sel;
  endfunction

endpackage

// File: verilog/addr_chan_router.sv
`timescale 1ns/1ns

module addr_chan_router (
  input  logic                    clk,
  input  logic                    rstn,
  // Master 0
  input  axi_pkg::addr_chan_t     m0_req,
  input  logic                    m0_valid,
  output logic                    m0_ready,
  // Master 1
  input  axi_pkg::addr_chan_t     m1_req,
  input  logic                    m1_valid,
  output logic                    m1_ready,
  // Slave 0
  output axi_pkg::slv_addr_chan_t s0_req,
  output logic                    s0_valid,
  input  logic                    s0_ready,
  // Slave 1
  output axi_pkg::slv_addr_chan_t s1_req,
  output logic                    s1_valid,
  input  logic                    s1_ready,
  // Default slave
  output axi_pkg::slv_addr_chan_t sd_req,
  output logic                    sd_valid,
  input  logic                    sd_ready
);

  import axi_pkg::*;
  import addr_map_pkg::*;

  addr_arb_lock_t lock_q;
  addr_arb_lock_t lock_d;
  logic           last_m1_q;
  slv_addr_chan_t mst_req;
  logic           mst_valid;
  logic           slv_ready;
  slave_sel_t     slv_sel;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_FREE;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Last grant starts at M1 so M0 wins the first tie
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      last_m1_q <= 1'b1;
    end else if (lock_q == LOCK_FREE && lock_d != LOCK_FREE) begin
      last_m1_q <= (lock_d == LOCK_M1);
    end
  end

  always_comb begin
    lock_d = lock_q;
    case (lock_q)
      LOCK_FREE: begin
        if (m0_valid && m1_valid) begin
          lock_d = last_m1_q ? LOCK_M0 : LOCK_M1;
        end else if (m0_valid) begin
          lock_d = LOCK_M0;
        end else if (m1_valid) begin
          lock_d = LOCK_M1;
        end
      end
      LOCK_M0, LOCK_M1: begin
        // Release on the transfer edge
        if (mst_valid && slv_ready) begin
          lock_d = LOCK_FREE;
        end
      end
      default: lock_d = LOCK_FREE;
    endcase
  end

  // Locked master onto the internal request
  always_comb begin
    mst_req   = '0;
    mst_valid = 1'b0;
    case (lock_q)
      LOCK_M0: begin
        mst_req   = extend_req(m0_req, MST_IDX_0);
        mst_valid = m0_valid;
      end
      LOCK_M1: begin
        mst_req   = extend_req(m1_req, MST_IDX_1);
        mst_valid = m1_valid;
      end
      default: begin
        mst_req   = '0;
        mst_valid = 1'b0;
      end
    endcase
  end

  assign m0_ready = (lock_q == LOCK_M0) && slv_ready;
  assign m1_ready = (lock_q == LOCK_M1) && slv_ready;

  assign slv_sel = addr_decode(mst_req.addr);

  // Steer to one slave, ready comes back from the same one
  always_comb begin
    s0_req    = '0;
    s1_req    = '0;
    sd_req    = '0;
    s0_valid  = 1'b0;
    s1_valid  = 1'b0;
    sd_valid  = 1'b0;
    slv_ready = 1'b0;
    case (slv_sel)
      SLAVE_0: begin
        s0_req    = mst_req;
        s0_valid  = mst_valid;
        slv_ready = s0_ready;
      end
      SLAVE_1: begin
        s1_req    = mst_req;
        s1_valid  = mst_valid;
        slv_ready = s1_ready;
      end
      default: begin
        sd_req    = mst_req;
        sd_valid  = mst_valid;
        slv_ready = sd_ready;
      end
    endcase
  end

endmodule

// File: verilog/default_slave_addr.sv
`timescale 1ns/1ns

module default_slave_addr (
  input  logic                    clk,
  input  logic                    rstn,
  input  axi_pkg::slv_addr_chan_t req,
  input  logic                    valid,
  output logic                    ready,
  output axi_pkg::decerr_t        decerr
);

  import axi_pkg::*;

  logic    xfer;
  logic    err_valid;
  ext_id_t err_ids;

  assign xfer = valid && ready;

  // One wait cycle, then accept and drop ready again
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      err_valid <= 1'b0;
    end else begin
      err_valid <= xfer;
    end
  end

  // ID of the accepted request
  always_ff @(posedge clk) begin
    if (xfer) begin
      err_ids <= req.ids;
    end
  end

  assign decerr.valid = err_valid;
  assign decerr.ids   = err_ids;

endmodule

// File: verilog/axi_addr_xbar.sv
`timescale 1ns/1ns

module axi_addr_xbar (
  input  logic                    clk,
  input  logic                    rstn,
  // AW masters
  input  axi_pkg::addr_chan_t     m0_aw,
  input  logic                    m0_aw_valid,
  output logic                    m0_aw_ready,
  input  axi_pkg::addr_chan_t     m1_aw,
  input  logic                    m1_aw_valid,
  output logic                    m1_aw_ready,
  // AW slaves
  output axi_pkg::slv_addr_chan_t s0_aw,
  output logic                    s0_aw_valid,
  input  logic                    s0_aw_ready,
  output axi_pkg::slv_addr_chan_t s1_aw,
  output logic                    s1_aw_valid,
  input  logic                    s1_aw_ready,
  // AR masters
  input  axi_pkg::addr_chan_t     m0_ar,
  input  logic                    m0_ar_valid,
  output logic                    m0_ar_ready,
  input  axi_pkg::addr_chan_t     m1_ar,
  input  logic                    m1_ar_valid,
  output logic                    m1_ar_ready,
  // AR slaves
  output axi_pkg::slv_addr_chan_t s0_ar,
  output logic                    s0_ar_valid,
  input  logic                    s0_ar_ready,
  output axi_pkg::slv_addr_chan_t s1_ar,
  output logic                    s1_ar_valid,
  input  logic                    s1_ar_ready,
  // Decode errors
  output axi_pkg::decerr_t        aw_decerr,
  output axi_pkg::decerr_t        ar_decerr
);

  import axi_pkg::*;

  // Default slave links, one per channel
  slv_addr_chan_t aw_sd_req;
  logic           aw_sd_valid;
  logic           aw_sd_ready;
  slv_addr_chan_t ar_sd_req;
  logic           ar_sd_valid;
  logic           ar_sd_ready;

  addr_chan_router u_aw_router (
    .clk      (clk),
    .rstn     (rstn),
    .m0_req   (m0_aw),
    .m0_valid (m0_aw_valid),
    .m0_ready (m0_aw_ready),
    .m1_req   (m1_aw),
    .m1_valid (m1_aw_valid),
    .m1_ready (m1_aw_ready),
    .s0_req   (s0_aw),
    .s0_valid (s0_aw_valid),
    .s0_ready (s0_aw_ready),
    .s1_req   (s1_aw),
    .s1_valid (s1_aw_valid),
    .s1_ready (s1_aw_ready),
    .sd_req   (aw_sd_req),
    .sd_valid (aw_sd_valid),
    .sd_ready (aw_sd_ready)
  );

  default_slave_addr u_aw_default (
    .clk    (clk),
    .rstn   (rstn),
    .req    (aw_sd_req),
    .valid  (aw_sd_valid),
    .ready  (aw_sd_ready),
    .decerr (aw_decerr)
  );

  addr_chan_router u_ar_router (
    .clk      (clk),
    .rstn     (rstn),
    .m0_req   (m0_ar),
    .m0_valid (m0_ar_valid),
    .m0_ready (m0_ar_ready),
    .m1_req   (m1_ar),
    .m1_valid (m1_ar_valid),
    .m1_ready (m1_ar_ready),
    .s0_req   (s0_ar),
    .s0_valid (s0_ar_valid),
    .s0_ready (s0_ar_ready),
    .s1_req   (s1_ar),
    .s1_valid (s1_ar_valid),
    .s1_ready (s1_ar_ready),
    .sd_req   (ar_sd_req),
    .sd_valid (ar_sd_valid),
    .sd_ready (ar_sd_ready)
  );

  default_slave_addr u_ar_default (
    .clk    (clk),
    .rstn   (rstn),
    .req    (ar_sd_req),
    .valid  (ar_sd_valid),
    .ready  (ar_sd_ready),
    .decerr (ar_decerr)
  );

endmodule

// File: dv/tb_axi_addr_xbar.sv
`timescale 1ns/1ns

module tb_axi_addr_xbar;

  import axi_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_REQ    = 40;
  localparam int TOTAL_REQ  = 4 * NUM_REQ;

  typedef struct packed {
    logic [1:0]     slv;
    slv_addr_chan_t req;
  } route_t;

  logic clk = 1'b0;
  logic rstn;

  // Index is channel * 2 + master (or slave), AW first
  addr_chan_t     m_req   [4];
  logic           m_valid [4];
  logic           m_ready [4];
  slv_addr_chan_t s_req   [4];
  logic           s_valid [4];
  logic           s_ready [4];
  decerr_t        decerr  [2];

  integer         seed = 32'hce19;
  slv_addr_chan_t exp_q [12][$];
  slv_addr_chan_t prev_req [4];
  logic           prev_wait [4];
  string          ch_name [2] = '{"aw", "ar"};
  int             want_next [2] = '{0, 0};
  int             issued [2] = '{0, 0};
  int             transfers [2] = '{0, 0};
  int             drivers_done = 0;
  int             rst_cycles = 0;
  int             value_errs = 0;
  int             proto_errs = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_addr_xbar u_axi_addr_xbar (
    .clk         (clk),
    .rstn        (rstn),
    .m0_aw       (m_req[0]),
    .m0_aw_valid (m_valid[0]),
    .m0_aw_ready (m_ready[0]),
    .m1_aw       (m_req[1]),
    .m1_aw_valid (m_valid[1]),
    .m1_aw_ready (m_ready[1]),
    .s0_aw       (s_req[0]),
    .s0_aw_valid (s_valid[0]),
    .s0_aw_ready (s_ready[0]),
    .s1_aw       (s_req[1]),
    .s1_aw_valid (s_valid[1]),
    .s1_aw_ready (s_ready[1]),
    .m0_ar       (m_req[2]),
    .m0_ar_valid (m_valid[2]),
    .m0_ar_ready (m_ready[2]),
    .m1_ar       (m_req[3]),
    .m1_ar_valid (m_valid[3]),
    .m1_ar_ready (m_ready[3]),
    .s0_ar       (s_req[2]),
    .s0_ar_valid (s_valid[2]),
    .s0_ar_ready (s_ready[2]),
    .s1_ar       (s_req[3]),
    .s1_ar_valid (s_valid[3]),
    .s1_ar_ready (s_ready[3]),
    .aw_decerr   (decerr[0]),
    .ar_decerr   (decerr[1])
  );

  // Slave 2 stands for the default slave
  function automatic route_t expected_route(input addr_chan_t req, input int mst);
    route_t rt;
    rt.req.ids.mst = mst;
    rt.req.ids.id  = req.id;
    rt.req.addr    = req.addr;
    rt.req.len     = req.len;
    rt.req.size    = req.size;
    rt.req.burst   = req.burst;
    if (req.addr < 32'h0001_0000) begin
      rt.slv = 2'd0;
    end else if (req.addr < 32'h0002_0000) begin
      rt.slv = 2'd1;
    end else begin
      rt.slv = 2'd2;
    end
    return rt;
  endfunction

  function automatic int queue_index(input int ch, input int mst, input int slv);
    return ch * 6 + mst * 3 + slv;
  endfunction

  function automatic addr_chan_t random_request();
    addr_chan_t  req;
    logic [31:0] rnd;
    logic [15:0] upper;
    rnd = $random(seed);
    case (rnd % 3)
      0: upper = 16'h0000;
      1: upper = 16'h0001;
      default: begin
        upper = rnd[31:16];
        // Keep it out of both windows
        if (upper < 16'h0002) upper = upper | 16'h8000;
      end
    endcase
    rnd = $random(seed);
    req.addr  = {upper, rnd[15:0]};
    req.id    = rnd[19:16];
    req.len   = rnd[23:20];
    req.size  = rnd[26:24];
    req.burst = burst_t'(rnd[28:27] % 3);
    return req;
  endfunction

  task automatic pop_and_compare(input string name, input int key,
                                 input slv_addr_chan_t got, input bit ids_only);
    slv_addr_chan_t exp;
    assert (exp_q[key].size() > 0) else begin
      $display("%s: transfer seen with no outstanding request for it", name);
      proto_errs++;
    end
    if (exp_q[key].size() > 0) begin
      exp = exp_q[key].pop_front();
      if (ids_only) begin
        assert (got.ids == exp.ids) else begin
          $display("ERR %s: expected %h, actual %h", name, exp.ids, got.ids);
          value_errs++;
        end
      end else begin
        assert (got == exp) else begin
          $display("ERR %s: expected %h, actual %h", name, exp, got);
          value_errs++;
        end
      end
    end
  endtask

  always @(negedge clk) begin : slave_ready
    logic [31:0] rnd;
    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      s_ready[k] = rnd[0];
    end
  end

  // All four masters start together, so the first tie is seen on both channels
  for (genvar gi = 0; gi < 4; gi++) begin : g_master
    localparam int CH  = gi / 2;
    localparam int MST = gi % 2;

    initial begin : drive
      addr_chan_t req;
      route_t     rt;
      int         gap;
      wait (rstn === 1'b1);
      for (int n = 0; n < NUM_REQ; n++) begin
        gap = (n == 0) ? 0 : $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
        req = random_request();
        rt  = expected_route(req, MST);
        exp_q[queue_index(CH, MST, rt.slv)].push_back(rt.req);
        issued[CH]++;
        m_req[gi]   = req;
        m_valid[gi] = 1'b1;
        @(posedge clk);
        while (!m_ready[gi]) @(posedge clk);
        @(negedge clk);
        m_valid[gi] = 1'b0;
        m_req[gi]   = '0;
      end
      drivers_done++;
    end
  end

  always @(posedge clk) begin : compare
    slv_addr_chan_t got;
    int             k;
    int             mst;
    if (rst_cycles == 0) begin
      for (k = 0; k < 4; k++) begin
        assert (s_valid[k] === 1'b0 && m_ready[k] === 1'b0) else begin
          $display("Slave valid or master ready %0d is not low around reset", k);
          proto_errs++;
        end
      end
      for (int ch = 0; ch < 2; ch++) begin
        assert (decerr[ch].valid === 1'b0) else begin
          $display("%s decode error pulse is not low around reset", ch_name[ch]);
          proto_errs++;
        end
      end
    end
    rst_cycles = rstn ? rst_cycles + 1 : 0;
    for (int ch = 0; ch < 2 && rstn; ch++) begin
      assert (!(s_valid[ch * 2] && s_valid[ch * 2 + 1])) else begin
        $display("%s channel drives both slaves at once", ch_name[ch]);
        proto_errs++;
      end
      for (int s = 0; s < 2; s++) begin
        k = ch * 2 + s;
        if (prev_wait[k]) begin
          assert (s_valid[k]) else begin
            $display("%s slave %0d valid dropped while ready was low", ch_name[ch], s);
            proto_errs++;
          end
          assert (s_req[k] == prev_req[k]) else begin
            $display("ERR %s_hold_s%0d: expected %h, actual %h",
                     ch_name[ch], s, prev_req[k], s_req[k]);
            value_errs++;
          end
        end
        if (s_valid[k]) begin
          if (s_ready[k]) begin
            transfers[ch]++;
          end
          mst = s_req[k].ids.mst;
          assert (mst < 2) else begin
            $display("%s slave %0d carries an unknown master index", ch_name[ch], s);
            proto_errs++;
          end
          if (mst < 2) begin
            assert (m_ready[ch * 2 + mst] == s_ready[k]) else begin
              $display("ERR %s_ready_m%0d: expected %b, actual %b",
                       ch_name[ch], mst, s_ready[k], m_ready[ch * 2 + mst]);
              value_errs++;
            end
            if (s_ready[k]) begin
              pop_and_compare($sformatf("%s_route_s%0d", ch_name[ch], s),
                              queue_index(ch, mst, s), s_req[k], 1'b0);
            end
          end
        end
        prev_wait[k] = s_valid[k] && !s_ready[k];
        prev_req[k]  = s_req[k];
      end
      if (decerr[ch].valid) begin
        transfers[ch]++;
        got     = '0;
        got.ids = decerr[ch].ids;
        mst     = decerr[ch].ids.mst;
        if (mst < 2) begin
          pop_and_compare($sformatf("%s_decerr", ch_name[ch]),
                          queue_index(ch, mst, 2), got, 1'b1);
        end else begin
          $display("%s decode error carries an unknown master index", ch_name[ch]);
          proto_errs++;
        end
      end
      // A waiting master must win the next grant
      for (int m = 0; m < 2; m++) begin
        if (m_valid[ch * 2 + m] && m_ready[ch * 2 + m]) begin
          if (want_next[ch] >= 0) begin
            assert (m == want_next[ch]) else begin
              $display("ERR %s_fairness: expected M%0d, actual M%0d",
                       ch_name[ch], want_next[ch], m);
              value_errs++;
            end
          end
          want_next[ch] = m_valid[ch * 2 + 1 - m] ? 1 - m : -1;
        end
      end
    end
  end

  initial begin : watchdog
    #(TOTAL_REQ * 40 * CLK_PERIOD);
    $display("Timeout: traffic did not finish within %0d ns", TOTAL_REQ * 40 * CLK_PERIOD);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    rstn = 1'b0;
    for (int k = 0; k < 4; k++) begin
      m_req[k]     = '0;
      m_valid[k]   = 1'b0;
      s_ready[k]   = 1'b0;
      prev_req[k]  = '0;
      prev_wait[k] = 1'b0;
    end
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    wait (drivers_done == 4);
    // Last decode error pulse follows its transfer by one cycle
    repeat (4) @(posedge clk);
    for (int ch = 0; ch < 2; ch++) begin
      assert (transfers[ch] == issued[ch]) else begin
        $display("ERR %s_count: expected %0d, actual %0d",
                 ch_name[ch], issued[ch], transfers[ch]);
        value_errs++;
      end
    end
    for (int q = 0; q < 12; q++) begin
      assert (exp_q[q].size() == 0) else begin
        $display("%0d requests never reached slave %0d of master %0d on %s",
                 exp_q[q].size(), q % 3, (q / 3) % 2, ch_name[q / 6]);
        proto_errs++;
      end
    end
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/addr_map_pkg.sv
verilog/addr_chan_router.sv
verilog/default_slave_addr.sv
verilog/axi_addr_xbar.sv
dv/tb_axi_addr_xbar.sv
